/* verilog/capture_consts.svh */
`ifndef CAPTURE_CONSTS_SVH
`define CAPTURE_CONSTS_SVH

// datapath widths
`define SAMPLE_W         12
`define WORD_W           36
`define COUNT_W          16
`define DOWNSAMPLE_W     13

// buffer depths
`define PRESAMPLE_DEPTH  64   // holds at most 63 presamples
`define WORD_DEPTH       256

// apb register map
`define REG_CTRL         8'h00   // bit 0 arm, bit 1 low_res
`define REG_PRESAMPLES   8'h04
`define REG_MAX_SAMPLES  8'h08
`define REG_DOWNSAMPLE   8'h0C
`define REG_STATUS       8'h10   // armed, done, empty, overflow
`define REG_DATA         8'h14

`endif

/* verilog/capture_pkg.sv */
`include "capture_consts.svh"

package capture_pkg;

    typedef logic [`SAMPLE_W-1:0]     sample_t;
    typedef logic [`WORD_W-1:0]       word_t;      // three samples, first on top
    typedef logic [`COUNT_W-1:0]      count_t;
    typedef logic [`DOWNSAMPLE_W-1:0] downsample_t;

    typedef logic [7:0]               apb_addr_t;
    typedef logic [31:0]              apb_data_t;

    // capture sequence
    typedef enum logic [2:0] {
        cs_idle,
        cs_armed,
        cs_pre_filling,
        cs_pre_full,
        cs_triggered,
        cs_done
    } capture_state_t;

endpackage

/* verilog/apb_capture_regs.sv */
`timescale 1ns/10ps
`include "capture_consts.svh"

module apb_capture_regs (
    input  logic                     adc_sampleclk,
    input  logic                     reset_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  capture_pkg::apb_addr_t   paddr_i,
    input  capture_pkg::apb_data_t   pwdata_i,
    input  logic [7:0]               byte_i,
    input  logic                     empty_i,
    input  logic                     armed_i,
    input  logic                     done_i,
    input  logic                     overflow_i,
    output capture_pkg::apb_data_t   prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,
    output logic                     arm_pulse_o,
    output logic                     low_res_o,
    output capture_pkg::count_t      presamples_o,
    output capture_pkg::count_t      max_samples_o,
    output capture_pkg::downsample_t downsample_o,
    output logic                     byte_pop_o
);
    import capture_pkg::*;

    logic access;     // access phase completes the transfer on this edge
    logic wr_done;
    logic rd_done;
    logic data_sel;
    logic mapped;

    assign access   = psel_i && penable_i;
    assign wr_done  = access && pwrite_i;
    assign rd_done  = access && !pwrite_i;
    assign data_sel = (paddr_i == `REG_DATA);
    assign pready_o = 1'b1;   // zero wait states

    assign arm_pulse_o = wr_done && (paddr_i == `REG_CTRL) && pwdata_i[0];
    assign byte_pop_o  = rd_done && data_sel && !empty_i;   // pop after the byte is taken
    assign pslverr_o   = access && (!mapped || (rd_done && data_sel && empty_i));

    always_comb begin
        mapped   = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            `REG_CTRL:        prdata_o = {30'd0, low_res_o, 1'b0};
            `REG_PRESAMPLES:  prdata_o = {16'd0, presamples_o};
            `REG_MAX_SAMPLES: prdata_o = {16'd0, max_samples_o};
            `REG_DOWNSAMPLE:  prdata_o = {19'd0, downsample_o};
            `REG_STATUS:      prdata_o = {28'd0, overflow_i, empty_i, done_i, armed_i};
            `REG_DATA:        prdata_o = empty_i ? '0 : {24'd0, byte_i};
            default:          mapped   = 1'b0;
        endcase
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset_i) begin
            low_res_o     <= 1'b0;
            presamples_o  <= '0;
            max_samples_o <= '0;
            downsample_o  <= '0;
        end else if (wr_done) begin
            case (paddr_i)
                `REG_CTRL:        low_res_o     <= pwdata_i[1];
                `REG_PRESAMPLES:  presamples_o  <= pwdata_i[`COUNT_W-1:0];
                `REG_MAX_SAMPLES: max_samples_o <= pwdata_i[`COUNT_W-1:0];
                `REG_DOWNSAMPLE:  downsample_o  <= pwdata_i[`DOWNSAMPLE_W-1:0];
                default: ;
            endcase
        end
    end

    // setup phase is always followed by the access phase
    a_setup_access: assert property (@(posedge adc_sampleclk) disable iff (reset_i)
        (psel_i && !penable_i) |=> (psel_i && penable_i));

endmodule

/* verilog/sample_decimator.sv */
`timescale 1ns/10ps

module sample_decimator (
    input  logic                     adc_sampleclk,
    input  logic                     reset_i,
    input  logic                     arm_i,
    input  logic                     sample_mask_i,
    input  capture_pkg::downsample_t downsample_i,
    output logic                     keep_o
);
    import capture_pkg::*;

    downsample_t skip_cnt;   // masked samples since the last kept one

    // first masked sample after arm is kept, then every (downsample + 1)-th
    assign keep_o = sample_mask_i && (skip_cnt == '0);

    always_ff @(posedge adc_sampleclk) begin
        if (reset_i || arm_i) begin
            skip_cnt <= '0;
        end else if (sample_mask_i) begin
            if (skip_cnt == downsample_i)
                skip_cnt <= '0;
            else
                skip_cnt <= skip_cnt + 1'b1;
        end
    end

endmodule

/* verilog/capture_fsm.sv */
`timescale 1ns/10ps

module capture_fsm (
    input  logic                adc_sampleclk,
    input  logic                reset_i,
    input  logic                arm_i,
    input  logic                trigger_i,
    input  capture_pkg::count_t presamples_i,
    input  capture_pkg::count_t max_samples_i,
    input  logic                sample_written_i,
    input  logic                fifo_empty_i,
    output logic                store_en_o,
    output logic                drain_o,
    output logic                forward_en_o,
    output logic                armed_o,
    output logic                done_o
);
    import capture_pkg::*;

    capture_state_t state;
    count_t         pre_cnt;       // presamples held in the fifo
    count_t         smp_cnt;       // samples passed on, presamples included
    count_t         pre_cnt_nxt;
    count_t         smp_cnt_nxt;
    logic           pre_state;
    logic           pre_at_limit;

    assign pre_state    = (state == cs_pre_filling) || (state == cs_pre_full);
    assign pre_at_limit = (pre_cnt == presamples_i);

    always_comb begin
        case (state)
            cs_armed:       store_en_o = (presamples_i != '0);
            cs_pre_filling,
            cs_pre_full:    store_en_o = 1'b1;
            cs_triggered:   store_en_o = (smp_cnt < max_samples_i);
            default:        store_en_o = 1'b0;
        endcase
    end

    // with the window full every new write pushes the oldest entry out
    assign drain_o      = pre_state && pre_at_limit && sample_written_i;
    assign forward_en_o = (state == cs_triggered) || (state == cs_done);
    assign armed_o      = (state != cs_idle);

    assign pre_cnt_nxt = (sample_written_i && !pre_at_limit) ? pre_cnt + 1'b1 : pre_cnt;
    assign smp_cnt_nxt = sample_written_i ? smp_cnt + 1'b1 : smp_cnt;

    always_ff @(posedge adc_sampleclk) begin
        if (reset_i) begin
            state   <= cs_idle;
            pre_cnt <= '0;
            smp_cnt <= '0;
            done_o  <= 1'b0;
        end else if (arm_i) begin
            state   <= cs_armed;   // rearm restarts from any state
            pre_cnt <= '0;
            smp_cnt <= '0;
            done_o  <= 1'b0;
        end else begin
            case (state)
                cs_armed: begin
                    pre_cnt <= pre_cnt_nxt;
                    if (presamples_i != '0)
                        state <= cs_pre_filling;
                    else if (trigger_i)
                        state <= cs_triggered;
                end
                cs_pre_filling,
                cs_pre_full: begin
                    pre_cnt <= pre_cnt_nxt;
                    if (trigger_i) begin
                        smp_cnt <= pre_cnt_nxt;   // presamples count toward the total
                        state   <= cs_triggered;
                    end else if (pre_cnt_nxt == presamples_i) begin
                        state <= cs_pre_full;
                    end
                end
                cs_triggered: begin
                    smp_cnt <= smp_cnt_nxt;
                    if (smp_cnt_nxt >= max_samples_i)
                        state <= cs_done;
                end
                cs_done: begin
                    // let the fifo run dry before reporting done
                    if (fifo_empty_i) begin
                        state  <= cs_idle;
                        done_o <= 1'b1;
                    end
                end
                default: state <= cs_idle;
            endcase
        end
    end

    // nothing may be stored once the capture is reported done
    a_done_empty: assert property (@(posedge adc_sampleclk) disable iff (reset_i)
        done_o |-> fifo_empty_i);

endmodule

/* verilog/presample_fifo.sv */
`timescale 1ns/10ps
`include "capture_consts.svh"

module presample_fifo (
    input  logic                 adc_sampleclk,
    input  logic                 reset_i,
    input  logic                 arm_i,
    input  capture_pkg::sample_t sample_i,
    input  logic                 sample_mask_i,
    input  logic                 keep_i,
    input  logic                 store_en_i,
    input  logic                 drain_i,
    input  logic                 forward_en_i,
    input  logic                 word_full_i,
    output capture_pkg::sample_t sample_o,
    output logic                 sample_valid_o,
    output logic                 sample_written_o,
    output logic                 fifo_empty_o,
    output logic                 overflow_o
);
    import capture_pkg::*;

    localparam int PTR_W = $clog2(`PRESAMPLE_DEPTH);

    sample_t           mem [`PRESAMPLE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              full;
    logic              offer;    // kept sample while storing
    logic              fwd_rd;
    logic              rd_en;

    assign full             = (count == (PTR_W+1)'(`PRESAMPLE_DEPTH));
    assign fifo_empty_o     = (count == '0);
    assign offer            = sample_mask_i && keep_i && store_en_i;
    assign sample_written_o = offer && !full;
    assign fwd_rd           = forward_en_i && !word_full_i && !fifo_empty_o && !drain_i;
    assign rd_en            = drain_i || fwd_rd;   // drained entries are dropped

    always_ff @(posedge adc_sampleclk) begin
        if (sample_written_o)
            mem[wr_ptr] <= sample_i;
        if (fwd_rd)
            sample_o <= mem[rd_ptr];
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset_i || arm_i) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            sample_valid_o <= 1'b0;
            overflow_o     <= 1'b0;
        end else begin
            sample_valid_o <= fwd_rd;
            if (sample_written_o)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({sample_written_o, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (offer && full)
                overflow_o <= 1'b1;   // sticky until the next arm
        end
    end

    a_no_underrun: assert property (@(posedge adc_sampleclk) disable iff (reset_i)
        rd_en |-> !fifo_empty_o);

endmodule

/* verilog/packed_readout.sv */
`timescale 1ns/10ps
`include "capture_consts.svh"

module packed_readout (
    input  logic                 adc_sampleclk,
    input  logic                 reset_i,
    input  logic                 arm_i,
    input  capture_pkg::sample_t sample_i,
    input  logic                 sample_valid_i,
    input  logic                 low_res_i,
    input  logic                 byte_pop_i,
    output logic [7:0]           byte_o,
    output logic                 empty_o,
    output logic                 word_full_o
);
    import capture_pkg::*;

    localparam int PTR_W = $clog2(`WORD_DEPTH);

    word_t             mem [`WORD_DEPTH];
    word_t             pack;        // shift register, oldest sample on top
    word_t             head;
    logic [1:0]        grp_cnt;
    logic              wr_pend;     // word complete, write this cycle
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic [3:0]        byte_cnt;
    logic [3:0]        tail;        // low nibble of the first word in a pair
    logic              last_byte;
    logic              rd_en;

    assign head    = mem[rd_ptr];
    assign empty_o = (count == '0);
    // one word of headroom for samples already in flight
    assign word_full_o = (count >= (PTR_W+1)'(`WORD_DEPTH - 1));

    assign last_byte = low_res_i ? (byte_cnt == 4'd2)
                                 : (byte_cnt == 4'd3) || (byte_cnt == 4'd8);
    assign rd_en     = byte_pop_i && last_byte && !empty_o;

    always_ff @(posedge adc_sampleclk) begin
        if (sample_valid_i)
            pack <= {pack[2*`SAMPLE_W-1:0], sample_i};
        if (wr_pend)
            mem[wr_ptr] <= pack;
        if (rd_en && !low_res_i && (byte_cnt == 4'd3))
            tail <= head[3:0];
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset_i || arm_i) begin
            grp_cnt  <= '0;
            wr_pend  <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            byte_cnt <= '0;
        end else begin
            wr_pend <= sample_valid_i && (grp_cnt == 2'd2);
            if (sample_valid_i)
                grp_cnt <= (grp_cnt == 2'd2) ? 2'd0 : grp_cnt + 2'd1;
            if (wr_pend)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_pend, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (byte_pop_i && !empty_o) begin
                if (last_byte && (low_res_i || (byte_cnt == 4'd8)))
                    byte_cnt <= '0;
                else
                    byte_cnt <= byte_cnt + 4'd1;
            end
        end
    end

    // low_res takes the upper 8 bits of each sample, full mode streams 12-bit samples
    always_comb begin
        if (low_res_i) begin
            case (byte_cnt)
                4'd0:    byte_o = head[35:28];
                4'd1:    byte_o = head[23:16];
                default: byte_o = head[11:4];
            endcase
        end else begin
            case (byte_cnt)
                4'd0:    byte_o = head[35:28];
                4'd1:    byte_o = head[27:20];
                4'd2:    byte_o = head[19:12];
                4'd3:    byte_o = head[11:4];
                4'd4:    byte_o = {tail, head[35:32]};   // straddles the word pair
                4'd5:    byte_o = head[31:24];
                4'd6:    byte_o = head[23:16];
                4'd7:    byte_o = head[15:8];
                default: byte_o = head[7:0];
            endcase
        end
    end

    a_no_overrun: assert property (@(posedge adc_sampleclk) disable iff (reset_i)
        wr_pend |-> (count != (PTR_W+1)'(`WORD_DEPTH)));

endmodule

/* verilog/capture_top.sv */
`timescale 1ns/10ps

module capture_top (
    input  logic                   adc_sampleclk,
    input  logic                   reset,
    input  capture_pkg::sample_t   adc_data_i,
    input  logic                   adc_write_mask_i,
    input  logic                   trigger_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  capture_pkg::apb_addr_t paddr_i,
    input  capture_pkg::apb_data_t pwdata_i,
    output capture_pkg::apb_data_t prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o
);
    import capture_pkg::*;

    logic        arm_pulse;
    logic        low_res;
    count_t      presamples;
    count_t      max_samples;
    downsample_t downsample;
    logic        byte_pop;
    logic [7:0]  data_byte;
    logic        data_empty;
    logic        keep;
    logic        store_en;
    logic        drain;
    logic        forward_en;
    logic        armed;
    logic        done;
    logic        overflow;
    logic        fifo_empty;
    logic        sample_written;
    sample_t     fwd_sample;
    logic        fwd_valid;
    logic        word_full;

    apb_capture_regs u_regs (
        .adc_sampleclk (adc_sampleclk),  .reset_i       (reset),
        .psel_i        (psel_i),         .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),       .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),       .byte_i        (data_byte),
        .empty_i       (data_empty),     .armed_i       (armed),
        .done_i        (done),           .overflow_i    (overflow),
        .prdata_o      (prdata_o),       .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),      .arm_pulse_o   (arm_pulse),
        .low_res_o     (low_res),        .presamples_o  (presamples),
        .max_samples_o (max_samples),    .downsample_o  (downsample),
        .byte_pop_o    (byte_pop)
    );

    sample_decimator u_decim (
        .adc_sampleclk (adc_sampleclk),  .reset_i       (reset),
        .arm_i         (arm_pulse),      .sample_mask_i (adc_write_mask_i),
        .downsample_i  (downsample),     .keep_o        (keep)
    );

    capture_fsm u_fsm (
        .adc_sampleclk    (adc_sampleclk),  .reset_i       (reset),
        .arm_i            (arm_pulse),      .trigger_i     (trigger_i),
        .presamples_i     (presamples),     .max_samples_i (max_samples),
        .sample_written_i (sample_written), .fifo_empty_i  (fifo_empty),
        .store_en_o       (store_en),       .drain_o       (drain),
        .forward_en_o     (forward_en),     .armed_o       (armed),
        .done_o           (done)
    );

    presample_fifo u_pre_fifo (
        .adc_sampleclk    (adc_sampleclk),  .reset_i        (reset),
        .arm_i            (arm_pulse),      .sample_i       (adc_data_i),
        .sample_mask_i    (adc_write_mask_i), .keep_i       (keep),
        .store_en_i       (store_en),       .drain_i        (drain),
        .forward_en_i     (forward_en),     .word_full_i    (word_full),
        .sample_o         (fwd_sample),     .sample_valid_o (fwd_valid),
        .sample_written_o (sample_written), .fifo_empty_o   (fifo_empty),
        .overflow_o       (overflow)
    );

    packed_readout u_readout (
        .adc_sampleclk  (adc_sampleclk),  .reset_i     (reset),
        .arm_i          (arm_pulse),      .sample_i    (fwd_sample),
        .sample_valid_i (fwd_valid),      .low_res_i   (low_res),
        .byte_pop_i     (byte_pop),       .byte_o      (data_byte),
        .empty_o        (data_empty),     .word_full_o (word_full)
    );

endmodule

/* tests/tb_capture.sv */
`timescale 1ns/10ps
`include "capture_consts.svh"

module tb_capture;
    import capture_pkg::*;

    // presamples, max samples, downsample, low_res, kept before trigger, bytes out
    typedef struct packed {
        int pre;
        int max;
        int ds;
        int low_res;
        int n_pre;
        int n_bytes;
    } row_t;

    localparam int NROWS = 6;
    localparam row_t ROWS [NROWS] = '{
        '{8,  24, 0, 1, 12, 24},    // low_res with presamples
        '{6,  30, 0, 0, 10, 45},    // full resolution gives nine bytes per six samples
        '{4,  18, 2, 1, 7,  18},    // keep every third masked sample
        '{20, 36, 1, 0, 5,  54},    // early trigger before the window fills
        '{0,  12, 0, 1, 3,  12},    // no presamples
        '{63, 72, 0, 0, 80, 108}    // deepest window, drain while full
    };

    logic      adc_sampleclk;
    logic      reset;
    sample_t   adc_data;
    logic      adc_mask;
    logic      trigger;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    // reference model of the decimator and capture window
    sample_t   kept_pre[$];
    sample_t   kept_post[$];
    bit        capturing;
    bit        post_trig;
    int        n_masked;   // masked samples since arming
    int        ds_cur;
    int        cycle_cnt;
    int        cycle_limit;

    capture_top uut (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .adc_data_i       (adc_data),
        .adc_write_mask_i (adc_mask),
        .trigger_i        (trigger),
        .psel_i           (psel),
        .penable_i        (penable),
        .pwrite_i         (pwrite),
        .paddr_i          (paddr),
        .pwdata_i         (pwdata),
        .prdata_o         (prdata),
        .pready_o         (pready),
        .pslverr_o        (pslverr)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #5 adc_sampleclk = ~adc_sampleclk;
    end

    always @(posedge adc_sampleclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Verification failed");
            $fatal(1, "timeout after %0d cycles, the capture never completed", cycle_cnt);
        end
    end

    // per-row bound assumes the mask is high three cycles in four
    function automatic int cycle_budget();
        int total;
        total = 200;
        for (int i = 0; i < NROWS; i++)
            total += 8 * (ROWS[i].n_pre + ROWS[i].max) * (ROWS[i].ds + 1)
                     + 4 * ROWS[i].n_bytes + 100;
        return total;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            abort_run("stopping on mismatch");
        end
    endtask

    // record what the DUT samples at the coming edge, then drive the next cycle
    task automatic tick();
        logic [31:0] rnd;
        logic        was_masked;
        was_masked = adc_mask;
        if (capturing && adc_mask) begin
            if (n_masked % (ds_cur + 1) == 0) begin
                if (post_trig)
                    kept_post.push_back(adc_data);
                else
                    kept_pre.push_back(adc_data);
            end
            n_masked++;
        end
        @(posedge adc_sampleclk);
        #1;
        if (was_masked)
            adc_data = adc_data + 12'd1;   // counter moves on each masked cycle
        rnd = $urandom();
        adc_mask = (rnd[1:0] != 2'b00);
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        tick();
        penable = 1'b1;
        #4;   // sample mid-cycle with outputs settled
        check_value("pready", 32'(pready), 32'd1);
        check_value("pslverr", 32'(pslverr), 32'd0);
        tick();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rd, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        tick();
        penable = 1'b1;
        #4;
        rd  = prdata;
        err = pslverr;
        check_value("pready", 32'(pready), 32'd1);
        tick();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_row(input int idx);
        row_t       row;
        apb_data_t  rd;
        logic       err;
        int         n_hold;
        int         n_read;
        sample_t    exp_s[$];
        logic [7:0] exp_b[$];
        row = ROWS[idx];
        capturing = 1'b0;
        apb_write(`REG_PRESAMPLES, apb_data_t'(row.pre));
        apb_write(`REG_MAX_SAMPLES, apb_data_t'(row.max));
        apb_write(`REG_DOWNSAMPLE, apb_data_t'(row.ds));
        apb_write(`REG_CTRL, {30'd0, row.low_res[0], 1'b1});
        // armed on the edge just passed
        kept_pre.delete();
        kept_post.delete();
        n_masked  = 0;
        ds_cur    = row.ds;
        post_trig = 1'b0;
        capturing = 1'b1;
        while (kept_pre.size() < row.n_pre)
            tick();
        trigger  = 1'b1;
        adc_mask = 1'b0;   // keep the trigger cycle free of samples
        tick();
        trigger   = 1'b0;
        post_trig = 1'b1;

        rd = '0;
        while (!rd[1])
            apb_read(`REG_STATUS, rd, err);
        check_value("status.armed", 32'(rd[0]), 32'd0);
        check_value("status.overflow", 32'(rd[3]), 32'd0);

        // newest presamples, then the samples after the trigger
        n_hold = (row.pre < kept_pre.size()) ? row.pre : kept_pre.size();
        for (int i = kept_pre.size() - n_hold; i < kept_pre.size(); i++)
            exp_s.push_back(kept_pre[i]);
        if (kept_post.size() < row.max - n_hold)
            abort_run("reference model is short of post-trigger samples");
        else
            for (int i = 0; i < row.max - n_hold; i++)
                exp_s.push_back(kept_post[i]);

        if (row.low_res != 0) begin
            foreach (exp_s[i])
                exp_b.push_back(exp_s[i][11:4]);
        end else begin
            for (int i = 0; i + 1 < exp_s.size(); i += 2) begin   // two samples make three bytes
                exp_b.push_back(exp_s[i][11:4]);
                exp_b.push_back({exp_s[i][3:0], exp_s[i+1][11:8]});
                exp_b.push_back(exp_s[i+1][7:0]);
            end
        end

        n_read = 0;
        apb_read(`REG_DATA, rd, err);
        while (!err) begin
            if (n_read >= exp_b.size())
                abort_run("DUT returned more data bytes than expected");
            else
                check_value("prdata", rd, 32'(exp_b[n_read]));
            n_read++;
            apb_read(`REG_DATA, rd, err);
        end
        check_value("prdata", rd, 32'd0);   // empty read gives zero
        check_value("byte count", 32'(n_read), 32'(row.n_bytes));
    endtask

    initial begin
        apb_data_t rd;
        logic      err;
        void'($urandom(32'h644c_2180));
        reset     = 1'b1;
        adc_data  = '0;
        adc_mask  = 1'b0;
        trigger   = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        capturing = 1'b0;
        post_trig = 1'b0;
        n_masked  = 0;
        ds_cur    = 0;
        cycle_cnt = 0;
        cycle_limit = cycle_budget();
        tick();
        tick();
        reset = 1'b0;

        apb_read(`REG_STATUS, rd, err);
        check_value("status", rd, 32'h0000_0004);   // only empty set
        check_value("pslverr", 32'(err), 32'd0);
        apb_read(`REG_DATA, rd, err);
        check_value("prdata", rd, 32'd0);
        check_value("pslverr", 32'(err), 32'd1);

        for (int i = 0; i < NROWS; i++)
            run_row(i);

        apb_read(8'h18, rd, err);   // unmapped
        check_value("pslverr", 32'(err), 32'd1);
        apb_read(`REG_DATA, rd, err);
        check_value("pslverr", 32'(err), 32'd1);

        $display("Verification passed");
        $finish;
    end

endmodule

/* project.f */
+incdir+verilog
verilog/capture_pkg.sv
verilog/apb_capture_regs.sv
verilog/sample_decimator.sv
verilog/capture_fsm.sv
verilog/presample_fifo.sv
verilog/packed_readout.sv
verilog/capture_top.sv
tests/tb_capture.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_capture
FILELIST  := project.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) verilog/capture_consts.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
